// ==== source/cache_geom_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Address geometry of the direct mapped L1 cache
////////////////////////////////////////////////////////////////////////////
package cache_geom_pkg;

    // A 16 bit byte address splits into tag, set index, word offset and byte bit
    // | 15 .. 10 | 9 .. 4 | 3 .. 1 | 0 |
    // |   tag    |  set   |  word  | x |

    localparam int tag_bits    = 6;  // Upper address bits kept in the tag store
    localparam int index_bits  = 6;  // Selects one of the sets
    localparam int offset_bits = 3;  // Selects one word inside a block

    // Number of sets, one block per set since the cache is direct mapped
    localparam int num_sets = 1 << index_bits;

    // Tag as compared against the upper address bits
    typedef logic [tag_bits-1:0] tag_t;

    // One tag store entry
    // The valid bit sits on top so an all zero entry reads as invalid
    typedef struct packed {
        logic valid;  // Set once the whole block has been filled from DRAM
        tag_t tag;    // Tag of the block held in this set
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Word and address types shared by the core bus and the DRAM bus
////////////////////////////////////////////////////////////////////////////
package mem_bus_pkg;

    localparam int addr_w = 16;  // Width of a byte address on both buses

    // Data word, the same on the core side, the DRAM side and in the cache
    typedef logic [15:0] word_t;

    // Byte address, bit 0 is never used since all accesses are whole words
    typedef logic [addr_w-1:0] addr_t;

    // Words moved from DRAM for one block fill
    localparam int words_per_block = 8;

endpackage

`default_nettype wire

// ==== source/cache_store.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Storage array with asynchronous read and synchronous write
////////////////////////////////////////////////////////////////////////////
module cache_store #(
    parameter type entry_t = logic,  // Payload kept in each entry
    parameter int  depth   = 64      // Number of entries
) (
    input  wire logic                     clk,
    input  wire logic                     rst,      // Clears every entry to zero
    input  wire logic                     wr_en,    // Write wr_data at the next edge
    input  wire logic [$clog2(depth)-1:0] wr_addr,  // Entry written when wr_en is high
    input  wire entry_t                   wr_data,  // New contents of the entry
    input  wire logic [$clog2(depth)-1:0] rd_addr,  // Entry read in this cycle
    output entry_t                        rd_data   // Contents of the entry at rd_addr
);

    // The array itself, one entry_t per location
    entry_t mem [depth];

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    // Reset clears all locations, which leaves every tag entry invalid
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;  // Single write per cycle
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////

    // No read register, so the hit decision and data_out settle in the
    // same cycle as the request
    assign rd_data = mem[rd_addr];

    // A write and a read to the same entry in one cycle return the old
    // contents until the edge, which the controller relies on during a fill

endmodule

`default_nettype wire

// ==== source/cache_fill_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Miss controller of the L1 cache
//
// Combines the tag store and data store outputs into the hit decision,
// runs the block fill from DRAM and steers both store write ports
////////////////////////////////////////////////////////////////////////////
module cache_fill_ctrl
    import cache_geom_pkg::*, mem_bus_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,                     // Returns the FSM to idle
    input  wire logic       enable,                  // Core request is present
    input  wire logic       on_chip_wr,              // Request is a write
    input  wire addr_t      on_chip_memory_address,  // Request address, held while busy
    input  wire word_t      on_chip_memory_data,     // Write data from the core
    input  wire word_t      off_chip_memory_data,    // Fill data returned by DRAM
    input  wire logic       memory_data_valid,       // One cycle strobe per DRAM word
    input  wire tag_entry_t tag_entry,               // Tag store entry of the request set
    input  wire word_t      data_word,               // Data store word of the request

    output addr_t                  off_chip_memory_address,  // Word requested from DRAM
    output logic                   fsm_busy,                 // Stalls the core on a miss
    output logic                   tag_wr_en,                // Tag store write strobe
    output tag_entry_t             tag_wr_data,              // Entry written at fill end
    output logic                   data_wr_en,               // Data store write strobe
    output logic [offset_bits-1:0] data_wr_offset,           // Word slot inside the block
    output word_t                  data_wr_data,             // Word written to the data store
    output word_t                  data_out                  // Read data back to the core
);

    ////////////////////////////////////////////////////////////////////////////
    // Request decode and hit detection
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        st_idle,  // Serving hits, waiting for a miss
        st_fill   // Pulling the block in from DRAM one word at a time
    } state_t;

    state_t                 state;
    logic [offset_bits-1:0] word_cnt;   // Next DRAM word of the block
    tag_t                   req_tag;    // Tag field of the request
    logic [offset_bits-1:0] req_word;   // Word offset of the request
    logic                   hit;        // Request set holds the requested block
    logic                   miss;       // Enabled request that is not a hit
    logic                   filling;    // FSM is in the fill state
    logic                   last_word;  // Current DRAM strobe completes the block

    assign req_tag  = on_chip_memory_address[addr_w-1 -: tag_bits];  // Bits 15 to 10
    assign req_word = on_chip_memory_address[1 +: offset_bits];      // Bits 3 to 1

    // Both the valid bit and the stored tag must agree with the request
    assign hit  = tag_entry.valid && (tag_entry.tag == req_tag);
    assign miss = enable && !hit;

    assign filling   = (state == st_fill);
    assign last_word = filling && memory_data_valid && (word_cnt == '1);

    ////////////////////////////////////////////////////////////////////////////
    // Fill FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            word_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (miss) begin
                        state    <= st_fill;  // Core is already stalled by fsm_busy
                        word_cnt <= '0;       // Always fill from the block base
                    end
                end
                st_fill: begin
                    if (memory_data_valid) begin
                        word_cnt <= word_cnt + 1'b1;  // Wraps to 0 after the eighth word
                        if (last_word) begin
                            state <= st_idle;  // Held request hits next cycle
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Busy rises with the miss itself, then stays high from the register
    // until the cycle after the last word is written
    assign fsm_busy = filling || miss;

    // Block base from the request plus the counter, bit 0 always zero
    // The counter sits at 0 while idle, so the first word is already on the bus
    assign off_chip_memory_address = {on_chip_memory_address[addr_w-1:offset_bits+1],
                                      word_cnt, 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Store write steering
    ////////////////////////////////////////////////////////////////////////////

    // DRAM words go in during a fill, core words on a write hit
    assign data_wr_en     = filling ? memory_data_valid : (enable && on_chip_wr && hit);
    assign data_wr_offset = filling ? word_cnt : req_word;
    assign data_wr_data   = filling ? off_chip_memory_data : on_chip_memory_data;

    // Tag goes valid on the same edge as the last data word
    assign tag_wr_en         = last_word;
    assign tag_wr_data.valid = 1'b1;
    assign tag_wr_data.tag   = req_tag;

    // Read data comes straight from the data store, valid only when hit is high
    assign data_out = data_word;

endmodule

`default_nettype wire

// ==== source/memory_system.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Direct mapped L1 cache in front of a read only DRAM bus
////////////////////////////////////////////////////////////////////////////
module memory_system
    import cache_geom_pkg::*, mem_bus_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,                     // Synchronous, active high
    input  wire logic  enable,                  // Core request present
    input  wire logic  on_chip_wr,              // Core request is a write
    input  wire addr_t on_chip_memory_address,  // Core byte address
    input  wire word_t on_chip_memory_data,     // Core write data

    // DRAM side
    input  wire word_t off_chip_memory_data,     // Word returned by DRAM
    input  wire logic  memory_data_valid,        // One cycle strobe with each word
    output addr_t      off_chip_memory_address,  // Word address requested from DRAM

    output logic       fsm_busy,  // Core must hold its request while high
    output word_t      data_out   // Read data, same cycle as the request
);

    localparam int data_depth = num_sets * words_per_block;  // One word per slot

    tag_entry_t             tag_entry;       // Tag store read of the request set
    tag_entry_t             tag_wr_data;     // Tag store write entry
    logic                   tag_wr_en;       // Tag store write strobe
    word_t                  data_word;       // Data store read of the request word
    word_t                  data_wr_data;    // Data store write word
    logic                   data_wr_en;      // Data store write strobe
    logic [offset_bits-1:0] data_wr_offset;  // Word slot written, counter during fills
    logic [index_bits-1:0]  set_index;       // Bits 9 to 4 of the request
    logic [offset_bits-1:0] word_offset;     // Bits 3 to 1 of the request

    assign set_index   = on_chip_memory_address[offset_bits+1 +: index_bits];
    assign word_offset = on_chip_memory_address[1 +: offset_bits];

    ////////////////////////////////////////////////////////////////////////////
    // Tag store and data store side by side
    ////////////////////////////////////////////////////////////////////////////

    cache_store #(.entry_t(tag_entry_t), .depth(num_sets)) u_tag_store (
        .clk    (clk),
        .rst    (rst),           // Leaves every set invalid
        .wr_en  (tag_wr_en),
        .wr_addr(set_index),
        .wr_data(tag_wr_data),
        .rd_addr(set_index),
        .rd_data(tag_entry)
    );

    // Index and offset together select one word of the array
    cache_store #(.entry_t(word_t), .depth(data_depth)) u_data_store (
        .clk    (clk),
        .rst    (rst),
        .wr_en  (data_wr_en),
        .wr_addr({set_index, data_wr_offset}),
        .wr_data(data_wr_data),
        .rd_addr({set_index, word_offset}),
        .rd_data(data_word)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Miss controller
    ////////////////////////////////////////////////////////////////////////////

    cache_fill_ctrl u_fill_ctrl (
        .clk                    (clk),
        .rst                    (rst),
        .enable                 (enable),
        .on_chip_wr             (on_chip_wr),
        .on_chip_memory_address (on_chip_memory_address),
        .on_chip_memory_data    (on_chip_memory_data),
        .off_chip_memory_data   (off_chip_memory_data),
        .memory_data_valid      (memory_data_valid),
        .tag_entry              (tag_entry),
        .data_word              (data_word),
        .off_chip_memory_address(off_chip_memory_address),
        .fsm_busy               (fsm_busy),
        .tag_wr_en              (tag_wr_en),
        .tag_wr_data            (tag_wr_data),
        .data_wr_en             (data_wr_en),
        .data_wr_offset         (data_wr_offset),
        .data_wr_data           (data_wr_data),
        .data_out               (data_out)
    );

endmodule

`default_nettype wire

// ==== dv/memory_system_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the miss controller
////////////////////////////////////////////////////////////////////////////
module memory_system_asserts
    import mem_bus_pkg::*;
(
    input wire logic  clk,
    input wire logic  rst,
    input wire logic  fsm_busy,                // Core stall
    input wire logic  memory_data_valid,       // DRAM word strobe
    input wire logic  tag_wr_en,               // Tag store write
    input wire logic  data_wr_en,              // Data store write
    input wire addr_t off_chip_memory_address  // Word requested from DRAM
);

    // DRAM words stored so far in the fill in progress
    logic [$clog2(words_per_block)-1:0] strobes_seen;

    always_ff @(posedge clk) begin
        if (rst || !fsm_busy) begin
            strobes_seen <= '0;  // Nothing pending outside a stall
        end else if (memory_data_valid && data_wr_en) begin
            strobes_seen <= strobes_seen + 1'b1;
        end
    end

    // The tag goes valid only on the edge that also stores the eighth DRAM word
    tag_write_in_fill : assert property (
        @(posedge clk) disable iff (rst)
        tag_wr_en |-> (data_wr_en && memory_data_valid &&
                       strobes_seen == words_per_block - 1)
    ) else $error("Tag store written without the last DRAM word of the block");

    // DRAM sees one steady address per word until the strobe answers it
    fill_addr_stable : assert property (
        @(posedge clk) disable iff (rst)
        (fsm_busy && !memory_data_valid) |=> $stable(off_chip_memory_address)
    ) else $error("Off-chip address moved before its data arrived");

    // Reset leaves the controller idle with no stall
    idle_after_reset : assert property (
        @(posedge clk)
        rst |=> !fsm_busy
    ) else $error("fsm_busy high in the cycle after reset");

endmodule

bind cache_fill_ctrl memory_system_asserts u_asserts (
    .clk                    (clk),
    .rst                    (rst),
    .fsm_busy               (fsm_busy),
    .memory_data_valid      (memory_data_valid),
    .tag_wr_en              (tag_wr_en),
    .data_wr_en             (data_wr_en),
    .off_chip_memory_address(off_chip_memory_address)
);

`default_nettype wire

// ==== dv/tb_memory_system.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Directed testbench for the L1 cache and its DRAM fill path
////////////////////////////////////////////////////////////////////////////
module tb_memory_system
    import cache_geom_pkg::*, mem_bus_pkg::*;
();

    logic  clk;
    logic  rst;
    logic  enable;
    logic  on_chip_wr;
    addr_t on_chip_memory_address;
    word_t on_chip_memory_data;
    word_t off_chip_memory_data;     // Driven by the DRAM model below
    logic  memory_data_valid;        // One cycle strobe from the DRAM model
    addr_t off_chip_memory_address;
    logic  fsm_busy;
    word_t data_out;

    integer seed = 32'h755511f0;  // Drives the DRAM latency draw
    addr_t  fill_addrs[$];        // DRAM addresses seen with each data strobe

    memory_system u_memory_system (
        .clk                    (clk),
        .rst                    (rst),
        .enable                 (enable),
        .on_chip_wr             (on_chip_wr),
        .on_chip_memory_address (on_chip_memory_address),
        .on_chip_memory_data    (on_chip_memory_data),
        .off_chip_memory_data   (off_chip_memory_data),
        .memory_data_valid      (memory_data_valid),
        .off_chip_memory_address(off_chip_memory_address),
        .fsm_busy               (fsm_busy),
        .data_out               (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address helpers and the DRAM contents rule
    ////////////////////////////////////////////////////////////////////////////

    // Builds a byte address from its tag, set and word fields
    function automatic addr_t make_addr(input tag_t tag, input logic [index_bits-1:0] set_idx,
                                        input logic [offset_bits-1:0] word_idx);
        return {tag, set_idx, word_idx, 1'b0};
    endfunction

    // Every DRAM word holds its own word address scrambled by a fixed pattern
    function automatic word_t dram_rule(input addr_t addr);
        return {addr[addr_w-1:1], 1'b0} ^ 16'h5a3c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // DRAM model and fill monitor
    ////////////////////////////////////////////////////////////////////////////

    // Answers one word per request with a latency of 1 to 4 cycles
    initial begin : dram_model
        int    delay;
        addr_t req_addr;
        memory_data_valid    = 1'b0;
        off_chip_memory_data = '0;
        forever begin
            @(negedge clk);
            if (!rst && fsm_busy) begin
                req_addr = off_chip_memory_address;  // Held by the controller until valid
                delay    = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                #1;
                off_chip_memory_data = dram_rule(req_addr);
                memory_data_valid    = 1'b1;
                @(posedge clk);
                #1;
                memory_data_valid = 1'b0;  // Strobe lasts exactly one cycle
            end
        end
    end

    always @(negedge clk) begin
        if (memory_data_valid) begin
            fill_addrs.push_back(off_chip_memory_address);  // Address under the strobe
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting, checking and bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", test_name, expected, actual);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    // Presents one request and holds it until the cache stops stalling
    task automatic access(input string test_name, input logic wr, input addr_t addr,
                          input word_t wdata, output word_t rdata, output logic first_busy);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        enable                 = 1'b1;
        on_chip_wr             = wr;
        on_chip_memory_address = addr;
        on_chip_memory_data    = wdata;
        @(negedge clk);
        first_busy = fsm_busy;  // A miss stalls within the request cycle
        while (fsm_busy) begin
            if (cycles == 200) begin
                abort_run({"Timeout waiting for fsm_busy to fall in ", test_name});
            end
            cycles++;
            @(negedge clk);
        end
        rdata = data_out;  // Held request has become a hit
    endtask

    task automatic read_expect(input string test_name, input addr_t addr,
                               input word_t expected, input logic expect_busy);
        word_t rdata;
        logic  busy;
        access(test_name, 1'b0, addr, '0, rdata, busy);
        check_value({test_name, " busy"}, 16'(expect_busy), 16'(busy));
        check_value({test_name, " data"}, expected, rdata);
    endtask

    task automatic write_expect(input string test_name, input addr_t addr,
                                input word_t wdata, input logic expect_busy);
        word_t rdata;
        logic  busy;
        access(test_name, 1'b1, addr, wdata, rdata, busy);
        check_value({test_name, " busy"}, 16'(expect_busy), 16'(busy));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        enable     = 1'b0;  // Keeps a stale request from missing right after reset
        on_chip_wr = 1'b0;
        rst        = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_cold_miss();
        read_expect("cold_miss", make_addr(6'd3, 6'd4, 3'd3),
                    dram_rule(make_addr(6'd3, 6'd4, 3'd3)), 1'b1);
        for (int i = 0; i < words_per_block; i++) begin  // Whole block now resident
            read_expect("cold_miss word", make_addr(6'd3, 6'd4, 3'(i)),
                        dram_rule(make_addr(6'd3, 6'd4, 3'(i))), 1'b0);
        end
    endtask

    task automatic test_fill_order();
        fill_addrs.delete();
        read_expect("fill_order", make_addr(6'd10, 6'd40, 3'd6),
                    dram_rule(make_addr(6'd10, 6'd40, 3'd6)), 1'b1);
        check_value("fill_order count", 16'(words_per_block), 16'(fill_addrs.size()));
        for (int i = 0; i < words_per_block; i++) begin
            check_value("fill_order address", make_addr(6'd10, 6'd40, 3'(i)), fill_addrs[i]);
        end
    endtask

    task automatic test_write_hit();
        write_expect("write_hit", make_addr(6'd3, 6'd4, 3'd2), 16'hbeef, 1'b0);
        read_expect("write_hit readback", make_addr(6'd3, 6'd4, 3'd2), 16'hbeef, 1'b0);
        // Neighbours on both sides stay untouched
        read_expect("write_hit below", make_addr(6'd3, 6'd4, 3'd1),
                    dram_rule(make_addr(6'd3, 6'd4, 3'd1)), 1'b0);
        read_expect("write_hit above", make_addr(6'd3, 6'd4, 3'd3),
                    dram_rule(make_addr(6'd3, 6'd4, 3'd3)), 1'b0);
    endtask

    task automatic test_write_miss();
        write_expect("write_miss", make_addr(6'd19, 6'd21, 3'd5), 16'h1357, 1'b1);
        read_expect("write_miss readback", make_addr(6'd19, 6'd21, 3'd5), 16'h1357, 1'b0);
        for (int i = 0; i < words_per_block; i++) begin
            if (i != 5) begin
                read_expect("write_miss other", make_addr(6'd19, 6'd21, 3'(i)),
                            dram_rule(make_addr(6'd19, 6'd21, 3'(i))), 1'b0);
            end
        end
    endtask

    // Same set as the cold miss block, different tag
    task automatic test_conflict();
        read_expect("conflict new tag", make_addr(6'd31, 6'd4, 3'd1),
                    dram_rule(make_addr(6'd31, 6'd4, 3'd1)), 1'b1);
        read_expect("conflict return", make_addr(6'd3, 6'd4, 3'd2),
                    dram_rule(make_addr(6'd3, 6'd4, 3'd2)), 1'b1);  // Earlier write is gone
    endtask

    task automatic test_enable_reset();
        @(posedge clk);
        #1;
        enable                 = 1'b0;
        on_chip_wr             = 1'b0;
        on_chip_memory_address = make_addr(6'd38, 6'd57, 3'd2);  // Absent block
        repeat (3) begin
            @(negedge clk);
            check_value("enable_low busy", 16'h0000, 16'(fsm_busy));
        end
        // The same block now misses, and reset lands in the middle of its fill
        @(posedge clk);
        #1;
        enable = 1'b1;
        @(negedge clk);
        check_value("reset fill started", 16'h0001, 16'(fsm_busy));
        apply_reset();
        @(negedge clk);
        check_value("reset busy", 16'h0000, 16'(fsm_busy));
        read_expect("reset refill", make_addr(6'd3, 6'd4, 3'd2),
                    dram_rule(make_addr(6'd3, 6'd4, 3'd2)), 1'b1);
    endtask

    initial begin
        rst                    = 1'b1;
        enable                 = 1'b0;
        on_chip_wr             = 1'b0;
        on_chip_memory_address = '0;
        on_chip_memory_data    = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_cold_miss();
        test_fill_order();
        test_write_hit();
        test_write_miss();
        test_conflict();
        test_enable_reset();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/cache_geom_pkg.sv
source/mem_bus_pkg.sv
source/cache_store.sv
source/cache_fill_ctrl.sv
source/memory_system.sv
dv/memory_system_asserts.sv
dv/tb_memory_system.sv

// ==== Makefile ====
# Verilator build and run of the memory system testbench

TOP := tb_memory_system
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f files.f
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation ended without passing"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
